/* common/rv_core_pkg.sv */
package rv_core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [XLEN-1:0]       addr_t;
    typedef logic [REG_ADDR_W-1:0] reg_idx_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        MEM_NONE, MEM_LOAD, MEM_STORE
    } mem_op_e;

    typedef enum logic [1:0] {
        FETCH_REQ, FETCH_WAIT, EXECUTE, MEM_WAIT
    } fetch_state_e;

    typedef struct packed {
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        logic       rd_wen;
        alu_op_e    alu_op;
        logic       src_a_pc;   // operand a is the pc
        logic       src_b_imm;  // operand b is the immediate
        logic       is_branch;
        logic       is_jal;
        logic       is_jalr;
        mem_op_e    mem_op;
        logic [2:0] funct3;
        word_t      imm;
    } ctrl_t;

    typedef struct packed {
        logic       valid;
        logic       we;
        addr_t      addr;
        word_t      wdata;
        logic [3:0] wstrb;
    } mem_req_t;

    typedef struct packed {
        logic  valid;
        word_t rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic       valid;
        mem_op_e    mem_op;
        logic [2:0] funct3;
        addr_t      addr;
        word_t      wdata;
    } lsu_req_t;

endpackage

/* source/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder (
    input  rv_core_pkg::word_t inst_i,
    output rv_core_pkg::ctrl_t ctrl_o
);

    // shared by op-imm and op-reg with sub only in register form
    function automatic rv_core_pkg::alu_op_e alu_sel(input logic [2:0] f3,
                                                     input logic alt,
                                                     input logic is_reg);
        case (f3)
            3'b000:  alu_sel = (alt && is_reg) ? rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
            3'b001:  alu_sel = rv_core_pkg::ALU_SLL;
            3'b010:  alu_sel = rv_core_pkg::ALU_SLT;
            3'b011:  alu_sel = rv_core_pkg::ALU_SLTU;
            3'b100:  alu_sel = rv_core_pkg::ALU_XOR;
            3'b101:  alu_sel = alt ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
            3'b110:  alu_sel = rv_core_pkg::ALU_OR;
            default: alu_sel = rv_core_pkg::ALU_AND;
        endcase
    endfunction

    rv_core_pkg::word_t imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [6:0] opcode;

    assign opcode = inst_i[6:0];
    assign imm_i  = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s  = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b  = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_u  = {inst_i[31:12], 12'd0};
    assign imm_j  = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                     inst_i[30:21], 1'b0};

    always_comb begin
        ctrl_o        = '0;
        ctrl_o.rd     = inst_i[11:7];
        ctrl_o.rs1    = inst_i[19:15];
        ctrl_o.rs2    = inst_i[24:20];
        ctrl_o.funct3 = inst_i[14:12];
        ctrl_o.alu_op = rv_core_pkg::ALU_ADD;
        ctrl_o.mem_op = rv_core_pkg::MEM_NONE;
        case (opcode)
            rv_core_pkg::OP_LUI: begin
                ctrl_o.rd_wen    = 1'b1;
                ctrl_o.alu_op    = rv_core_pkg::ALU_PASS_B;
                ctrl_o.src_b_imm = 1'b1;
                ctrl_o.imm       = imm_u;
            end
            rv_core_pkg::OP_AUIPC: begin
                ctrl_o.rd_wen    = 1'b1;
                ctrl_o.src_a_pc  = 1'b1;
                ctrl_o.src_b_imm = 1'b1;
                ctrl_o.imm       = imm_u;
            end
            rv_core_pkg::OP_JAL: begin
                ctrl_o.rd_wen = 1'b1;
                ctrl_o.is_jal = 1'b1;
                ctrl_o.imm    = imm_j;
            end
            rv_core_pkg::OP_JALR: begin
                ctrl_o.rd_wen  = 1'b1;
                ctrl_o.is_jalr = 1'b1;
                ctrl_o.imm     = imm_i;
            end
            rv_core_pkg::OP_BRANCH: begin
                ctrl_o.is_branch = 1'b1;
                ctrl_o.imm       = imm_b;
            end
            rv_core_pkg::OP_LOAD: begin
                ctrl_o.rd_wen    = 1'b1;  // written back on lsu done
                ctrl_o.src_b_imm = 1'b1;
                ctrl_o.mem_op    = rv_core_pkg::MEM_LOAD;
                ctrl_o.imm       = imm_i;
            end
            rv_core_pkg::OP_STORE: begin
                ctrl_o.src_b_imm = 1'b1;
                ctrl_o.mem_op    = rv_core_pkg::MEM_STORE;
                ctrl_o.imm       = imm_s;
            end
            rv_core_pkg::OP_IMM: begin
                ctrl_o.rd_wen    = 1'b1;
                ctrl_o.src_b_imm = 1'b1;
                ctrl_o.alu_op    = alu_sel(inst_i[14:12], inst_i[30], 1'b0);
                ctrl_o.imm       = imm_i;
            end
            rv_core_pkg::OP_REG: begin
                ctrl_o.rd_wen = 1'b1;
                ctrl_o.alu_op = alu_sel(inst_i[14:12], inst_i[30], 1'b1);
            end
            default: ;  // no-op
        endcase
    end

endmodule

/* source/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic                  clock,
    input  logic                  rst_n_i,
    input  rv_core_pkg::reg_idx_t rs1_i,
    input  rv_core_pkg::reg_idx_t rs2_i,
    input  rv_core_pkg::reg_idx_t rd_i,
    input  logic                  rd_wen_i,
    input  rv_core_pkg::word_t    rd_data_i,
    output rv_core_pkg::word_t    rs1_data_o,
    output rv_core_pkg::word_t    rs2_data_o
);

    rv_core_pkg::word_t regs [1:31];  // no storage for x0

    always_ff @(posedge clock) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_wen_i && (rd_i != '0)) begin
            regs[rd_i] <= rd_data_i;
        end
    end

    assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

/* source/exec_unit.sv */
`timescale 1ns/1ps

module exec_unit (
    input  rv_core_pkg::ctrl_t ctrl_i,
    input  rv_core_pkg::addr_t pc_i,
    input  rv_core_pkg::word_t rs1_data_i,
    input  rv_core_pkg::word_t rs2_data_i,
    output rv_core_pkg::word_t result_o,
    output logic               branch_taken_o,
    output rv_core_pkg::addr_t jump_target_o
);

    rv_core_pkg::word_t op_a, op_b, jalr_sum;
    logic [4:0] shamt;

    assign op_a  = ctrl_i.src_a_pc  ? pc_i       : rs1_data_i;
    assign op_b  = ctrl_i.src_b_imm ? ctrl_i.imm : rs2_data_i;
    assign shamt = op_b[4:0];

    always_comb begin
        case (ctrl_i.alu_op)
            rv_core_pkg::ALU_SUB:    result_o = op_a - op_b;
            rv_core_pkg::ALU_SLL:    result_o = op_a << shamt;
            rv_core_pkg::ALU_SLT:    result_o = {31'd0, $signed(op_a) < $signed(op_b)};
            rv_core_pkg::ALU_SLTU:   result_o = {31'd0, op_a < op_b};
            rv_core_pkg::ALU_XOR:    result_o = op_a ^ op_b;
            rv_core_pkg::ALU_SRL:    result_o = op_a >> shamt;
            rv_core_pkg::ALU_SRA:    result_o = $signed(op_a) >>> shamt;
            rv_core_pkg::ALU_OR:     result_o = op_a | op_b;
            rv_core_pkg::ALU_AND:    result_o = op_a & op_b;
            rv_core_pkg::ALU_PASS_B: result_o = op_b;
            default:                 result_o = op_a + op_b;  // also lsu address
        endcase
    end

    always_comb begin
        case (ctrl_i.funct3)
            3'b000:  branch_taken_o = rs1_data_i == rs2_data_i;
            3'b001:  branch_taken_o = rs1_data_i != rs2_data_i;
            3'b100:  branch_taken_o = $signed(rs1_data_i) <  $signed(rs2_data_i);
            3'b101:  branch_taken_o = $signed(rs1_data_i) >= $signed(rs2_data_i);
            3'b110:  branch_taken_o = rs1_data_i <  rs2_data_i;
            3'b111:  branch_taken_o = rs1_data_i >= rs2_data_i;
            default: branch_taken_o = 1'b0;
        endcase
    end

    assign jalr_sum      = rs1_data_i + ctrl_i.imm;
    assign jump_target_o = ctrl_i.is_jalr ? {jalr_sum[31:1], 1'b0} : pc_i + ctrl_i.imm;

endmodule

/* fetch/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit (
    input  logic                  clock,
    input  logic                  rst_n_i,
    input  rv_core_pkg::mem_rsp_t ifu_rsp_i,
    input  logic                  branch_taken_i,
    input  rv_core_pkg::addr_t    jump_target_i,
    input  logic                  lsu_done_i,
    input  rv_core_pkg::ctrl_t    ctrl_i,
    output rv_core_pkg::mem_req_t ifu_req_o,
    output rv_core_pkg::addr_t    pc_o,
    output rv_core_pkg::word_t    inst_o,
    output logic                  exec_o
);

    rv_core_pkg::fetch_state_e state_q, state_d;
    rv_core_pkg::addr_t        pc_q, next_pc;
    rv_core_pkg::word_t        inst_q;
    logic run_q;  // first cycle out of reset
    logic is_mem, take_jump, pc_upd;

    assign is_mem    = ctrl_i.mem_op != rv_core_pkg::MEM_NONE;
    assign take_jump = ctrl_i.is_jal | ctrl_i.is_jalr | (ctrl_i.is_branch & branch_taken_i);
    assign next_pc   = take_jump ? jump_target_i : pc_q + 32'd4;
    assign pc_upd    = (state_q == rv_core_pkg::EXECUTE && !is_mem) ||
                       (state_q == rv_core_pkg::MEM_WAIT && lsu_done_i);

    always_comb begin
        state_d = state_q;
        case (state_q)
            rv_core_pkg::FETCH_REQ:  if (run_q) state_d = rv_core_pkg::FETCH_WAIT;
            rv_core_pkg::FETCH_WAIT: if (ifu_rsp_i.valid) state_d = rv_core_pkg::EXECUTE;
            rv_core_pkg::EXECUTE:    state_d = is_mem ? rv_core_pkg::MEM_WAIT
                                                      : rv_core_pkg::FETCH_REQ;
            default:                 if (lsu_done_i) state_d = rv_core_pkg::FETCH_REQ;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst_n_i) begin
            state_q <= rv_core_pkg::FETCH_REQ;
            pc_q    <= '0;
            run_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            run_q   <= 1'b1;
            if (pc_upd) pc_q <= next_pc;
        end
    end

    always_ff @(posedge clock) begin
        if (state_q == rv_core_pkg::FETCH_WAIT && ifu_rsp_i.valid) inst_q <= ifu_rsp_i.rdata;
    end

    assign ifu_req_o = '{valid: run_q && (state_q == rv_core_pkg::FETCH_REQ),
                         we: 1'b0, addr: pc_q, wdata: '0, wstrb: '0};
    assign pc_o   = pc_q;
    assign inst_o = inst_q;
    assign exec_o = state_q == rv_core_pkg::EXECUTE;

endmodule

/* lsu/load_store_unit.sv */
`timescale 1ns/1ps

module load_store_unit (
    input  logic                  clock,
    input  logic                  rst_n_i,
    input  rv_core_pkg::lsu_req_t lsu_req_i,
    input  rv_core_pkg::mem_rsp_t lsu_rsp_i,
    output rv_core_pkg::mem_req_t lsu_mem_o,
    output logic                  done_o,
    output rv_core_pkg::word_t    load_data_o
);

    logic [1:0] off;
    logic [1:0] off_q;
    logic [2:0] funct3_q;
    logic [3:0] strb;
    logic       done_q;
    rv_core_pkg::word_t lane_data, shifted, load_q;

    assign off = lsu_req_i.addr[1:0];

    always_comb begin
        case (lsu_req_i.funct3[1:0])
            2'b00: begin
                lane_data = {4{lsu_req_i.wdata[7:0]}};
                strb      = 4'b0001 << off;
            end
            2'b01: begin
                lane_data = {2{lsu_req_i.wdata[15:0]}};
                strb      = 4'b0011 << {off[1], 1'b0};
            end
            default: begin
                lane_data = lsu_req_i.wdata;
                strb      = 4'b1111;
            end
        endcase
    end

    assign lsu_mem_o = '{valid: lsu_req_i.valid,
                         we:    lsu_req_i.mem_op == rv_core_pkg::MEM_STORE,
                         addr:  {lsu_req_i.addr[31:2], 2'b00},
                         wdata: lane_data,
                         wstrb: (lsu_req_i.mem_op == rv_core_pkg::MEM_STORE) ? strb : 4'b0000};

    assign shifted = lsu_rsp_i.rdata >> {off_q, 3'b000};

    always_ff @(posedge clock) begin
        if (lsu_req_i.valid) begin
            off_q    <= off;
            funct3_q <= lsu_req_i.funct3;
        end
        if (lsu_rsp_i.valid) begin
            case (funct3_q)
                3'b000:  load_q <= {{24{shifted[7]}}, shifted[7:0]};
                3'b001:  load_q <= {{16{shifted[15]}}, shifted[15:0]};
                3'b100:  load_q <= {24'd0, shifted[7:0]};
                3'b101:  load_q <= {16'd0, shifted[15:0]};
                default: load_q <= shifted;  // lw with off 0
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n_i) done_q <= 1'b0;
        else          done_q <= lsu_rsp_i.valid;
    end

    assign done_o      = done_q;
    assign load_data_o = load_q;

endmodule

/* source/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                  clock,
    input  logic                  rst_n_i,
    input  rv_core_pkg::mem_req_t ifu_req_i,
    input  rv_core_pkg::mem_req_t lsu_req_i,
    input  rv_core_pkg::mem_rsp_t mem_rsp_i,
    output rv_core_pkg::mem_rsp_t ifu_rsp_o,
    output rv_core_pkg::mem_rsp_t lsu_rsp_o,
    output rv_core_pkg::mem_req_t mem_req_o
);

    logic owner_lsu_q;  // owner of the access in flight

    // data side wins on a collision
    assign mem_req_o = lsu_req_i.valid ? lsu_req_i : ifu_req_i;

    always_ff @(posedge clock) begin
        if (!rst_n_i) begin
            owner_lsu_q <= 1'b0;
        end else if (mem_req_o.valid) begin
            owner_lsu_q <= lsu_req_i.valid;
        end
    end

    assign ifu_rsp_o.valid = mem_rsp_i.valid & ~owner_lsu_q;
    assign ifu_rsp_o.rdata = mem_rsp_i.rdata;
    assign lsu_rsp_o.valid = mem_rsp_i.valid & owner_lsu_q;
    assign lsu_rsp_o.rdata = mem_rsp_i.rdata;

endmodule

/* source/rv_core_top.sv */
`timescale 1ns/1ps

module rv_core_top (
    input  logic                  clock,
    input  logic                  rst_n_i,
    output rv_core_pkg::mem_req_t mem_req_o,
    input  rv_core_pkg::mem_rsp_t mem_rsp_i
);

    // fetch
    rv_core_pkg::mem_req_t ifu_req;
    rv_core_pkg::mem_rsp_t ifu_rsp;
    rv_core_pkg::addr_t    pc;
    rv_core_pkg::word_t    inst;
    logic                  exec;

    // decode, regfile, execute
    rv_core_pkg::ctrl_t    ctrl;
    rv_core_pkg::word_t    rs1_data, rs2_data;
    rv_core_pkg::word_t    exu_result;
    logic                  branch_taken;
    rv_core_pkg::addr_t    jump_target;

    // lsu and writeback
    rv_core_pkg::lsu_req_t lsu_req;
    rv_core_pkg::mem_req_t lsu_mem_req;
    rv_core_pkg::mem_rsp_t lsu_rsp;
    logic                  lsu_done;
    rv_core_pkg::word_t    load_data;
    rv_core_pkg::word_t    rd_data;
    logic                  rd_wen;
    logic                  is_mem;

    assign is_mem = ctrl.mem_op != rv_core_pkg::MEM_NONE;

    assign lsu_req = '{valid: exec && is_mem, mem_op: ctrl.mem_op, funct3: ctrl.funct3,
                       addr: exu_result, wdata: rs2_data};

    // loads write back a cycle after the response and all else in execute
    assign rd_wen  = (exec && ctrl.rd_wen && !is_mem) ||
                     (lsu_done && ctrl.mem_op == rv_core_pkg::MEM_LOAD);
    assign rd_data = lsu_done                    ? load_data :
                     (ctrl.is_jal | ctrl.is_jalr) ? pc + 32'd4 : exu_result;

    fetch_unit ifu_u0 (
        .clock          ( clock        ),
        .rst_n_i        ( rst_n_i      ),
        .ifu_rsp_i      ( ifu_rsp      ),
        .branch_taken_i ( branch_taken ),
        .jump_target_i  ( jump_target  ),
        .lsu_done_i     ( lsu_done     ),
        .ctrl_i         ( ctrl         ),
        .ifu_req_o      ( ifu_req      ),
        .pc_o           ( pc           ),
        .inst_o         ( inst         ),
        .exec_o         ( exec         )
    );

    instr_decoder idu_u0 (
        .inst_i ( inst ),
        .ctrl_o ( ctrl )
    );

    reg_file regfile_u0 (
        .clock      ( clock    ),
        .rst_n_i    ( rst_n_i  ),
        .rs1_i      ( ctrl.rs1 ),
        .rs2_i      ( ctrl.rs2 ),
        .rd_i       ( ctrl.rd  ),
        .rd_wen_i   ( rd_wen   ),
        .rd_data_i  ( rd_data  ),
        .rs1_data_o ( rs1_data ),
        .rs2_data_o ( rs2_data )
    );

    exec_unit exu_u0 (
        .ctrl_i         ( ctrl         ),
        .pc_i           ( pc           ),
        .rs1_data_i     ( rs1_data     ),
        .rs2_data_i     ( rs2_data     ),
        .result_o       ( exu_result   ),
        .branch_taken_o ( branch_taken ),
        .jump_target_o  ( jump_target  )
    );

    load_store_unit lsu_u0 (
        .clock       ( clock       ),
        .rst_n_i     ( rst_n_i     ),
        .lsu_req_i   ( lsu_req     ),
        .lsu_rsp_i   ( lsu_rsp     ),
        .lsu_mem_o   ( lsu_mem_req ),
        .done_o      ( lsu_done    ),
        .load_data_o ( load_data   )
    );

    mem_arbiter arbiter_u0 (
        .clock     ( clock       ),
        .rst_n_i   ( rst_n_i     ),
        .ifu_req_i ( ifu_req     ),
        .lsu_req_i ( lsu_mem_req ),
        .mem_rsp_i ( mem_rsp_i   ),
        .ifu_rsp_o ( ifu_rsp     ),
        .lsu_rsp_o ( lsu_rsp     ),
        .mem_req_o ( mem_req_o   )
    );

endmodule

/* verification/rv_core_ref.svh */
`ifndef RV_CORE_REF_SVH
`define RV_CORE_REF_SVH

function automatic int rnd(input int n);
    rnd = $unsigned($random(seed)) % n;
endfunction

function automatic logic [31:0] enc_r(input int f7, input int rs2, input int rs1,
                                      input int f3, input int rd, input int op);
    enc_r = {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
endfunction

function automatic logic [31:0] enc_i(input int imm, input int rs1, input int f3,
                                      input int rd, input int op);
    enc_i = {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
endfunction

function automatic logic [31:0] enc_s(input int imm, input int rs2, input int rs1, input int f3);
    enc_s = {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'h23};
endfunction

function automatic logic [31:0] enc_b(input int imm, input int rs2, input int rs1, input int f3);
    enc_b = {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
endfunction

function automatic logic [31:0] enc_u(input int imm, input int rd, input int op);
    enc_u = {imm[19:0], rd[4:0], op[6:0]};
endfunction

function automatic logic [31:0] enc_j(input int imm, input int rd);
    enc_j = {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
endfunction

function automatic void put(input logic [31:0] w);
    mem[n_prog] = w;
    n_prog++;
endfunction

// offset from x30 kept naturally aligned for the access size
function automatic int data_off(input int f3);
    data_off = rnd(64) * 4 + ((f3[1:0] == 0) ? rnd(4) : (f3[1:0] == 1) ? rnd(2) * 2 : 0);
endfunction

function automatic void gen_program();
    int f3;
    int rd;
    int sel;
    int imm;
    n_prog = 0;
    put(enc_u(2, 30, 'h37));  // x30 = data base 0x2000
    for (int r = 1; r < 30; r++) begin
        put(enc_u($random(seed), r, 'h37));
        put(enc_i($random(seed), r, 0, r, 'h13));
    end
    for (int k = 0; k < 80; k++) begin
        sel = rnd(8);
        rd  = rnd(30);
        f3  = rnd(8);
        case (sel)
            0, 1, 2: put(enc_r(((f3 == 0 || f3 == 5) && rnd(2) == 1) ? 'h20 : 0,
                               rnd(30), rnd(30), f3, rd, 'h33));
            3: begin
                imm = (f3 == 1) ? rnd(32) : (f3 == 5) ? rnd(32) + rnd(2) * 'h400 : $random(seed);
                put(enc_i(imm, rnd(30), f3, rd, 'h13));
            end
            4: put(enc_u($random(seed), rd, (rnd(2) == 1) ? 'h37 : 'h17));
            5: begin
                f3 = rnd(3);
                put(enc_s(data_off(f3), rnd(30), 30, f3));
            end
            6: begin
                f3 = rnd(5);
                if (f3 > 2) f3 = f3 + 1;  // lbu, lhu
                put(enc_i(data_off(f3), 30, f3, rd, 'h03));
            end
            default: begin
                f3 = rnd(6);
                if (f3 > 1) f3 = f3 + 2;
                put(enc_b((2 + rnd(3)) * 4, rnd(30), rnd(30), f3));
            end
        endcase
    end
    for (int k = 0; k < 4; k++) put(enc_i(5, 1, 0, 0, 'h13));  // writes to x0
    put(enc_j(8, 5));
    put(enc_i(1, 8, 0, 8, 'h13));  // skipped
    put(enc_u(0, 6, 'h17));
    put(enc_i(13, 6, 0, 7, 'h67));  // odd target with bit 0 dropped
    put(enc_i(1, 9, 0, 9, 'h13));   // skipped
    for (int r = 0; r < 32; r++) put(enc_s(1024 + 4 * r, r, 30, 2));
    put(enc_j(0, 0));
endfunction

function automatic logic [31:0] alu(input logic [2:0] f3, input logic alt,
                                    input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'd0:    alu = alt ? a - b : a + b;
        3'd1:    alu = a << b[4:0];
        3'd2:    alu = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3:    alu = (a < b) ? 32'd1 : 32'd0;
        3'd4:    alu = a ^ b;
        3'd5:    alu = alt ? $signed(a) >>> b[4:0] : a >> b[4:0];
        3'd6:    alu = a | b;
        default: alu = a & b;
    endcase
endfunction

function automatic void rv_core_ref();
    logic [31:0] x [0:31];
    logic [31:0] pc, npc, inst, res, a, w, sh, im_i, im_s, im_b;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic        wr, take;
    store_t      st;
    for (int r = 0; r < 32; r++) x[r] = '0;
    pc = '0;
    n_exec = 0;
    while (n_exec < 20000) begin
        inst = ref_mem[pc[13:2]];
        n_exec++;
        f3   = inst[14:12];
        rd   = inst[11:7];
        im_i = {{20{inst[31]}}, inst[31:20]};
        im_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        im_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        npc  = pc + 32'd4;
        wr   = 1'b1;
        res  = '0;
        case (inst[6:0])
            7'h37: res = {inst[31:12], 12'd0};
            7'h17: res = pc + {inst[31:12], 12'd0};
            7'h6f: begin
                res = pc + 32'd4;
                npc = pc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            7'h67: begin
                res = pc + 32'd4;
                npc = (x[inst[19:15]] + im_i) & ~32'd1;
            end
            7'h63: begin
                wr = 1'b0;
                a  = x[inst[19:15]];
                w  = x[inst[24:20]];
                case (f3)
                    3'd0:    take = a == w;
                    3'd1:    take = a != w;
                    3'd4:    take = $signed(a) < $signed(w);
                    3'd5:    take = $signed(a) >= $signed(w);
                    3'd6:    take = a < w;
                    default: take = a >= w;
                endcase
                if (take) npc = pc + im_b;
            end
            7'h03: begin
                a  = x[inst[19:15]] + im_i;
                sh = ref_mem[a[13:2]] >> {a[1:0], 3'b000};
                case (f3)
                    3'd0:    res = {{24{sh[7]}}, sh[7:0]};
                    3'd1:    res = {{16{sh[15]}}, sh[15:0]};
                    3'd4:    res = {24'd0, sh[7:0]};
                    3'd5:    res = {16'd0, sh[15:0]};
                    default: res = sh;
                endcase
            end
            7'h23: begin
                wr = 1'b0;
                a  = x[inst[19:15]] + im_s;
                w  = x[inst[24:20]];
                st.addr = {a[31:2], 2'b00};
                case (f3[1:0])
                    2'd0:    st = '{addr: st.addr, data: {4{w[7:0]}}, strb: 4'b0001 << a[1:0]};
                    2'd1:    st = '{addr: st.addr, data: {2{w[15:0]}}, strb: 4'b0011 << a[1:0]};
                    default: st = '{addr: st.addr, data: w, strb: 4'b1111};
                endcase
                for (int b = 0; b < 4; b++) begin
                    if (st.strb[b]) ref_mem[a[13:2]][8*b +: 8] = st.data[8*b +: 8];
                end
                exp_q.push_back(st);
            end
            7'h13: res = alu(f3, (f3 == 3'd5) & inst[30], x[inst[19:15]], im_i);
            7'h33: res = alu(f3, inst[30], x[inst[19:15]], x[inst[24:20]]);
            default: wr = 1'b0;
        endcase
        if (wr && rd != 5'd0) x[rd] = res;
        if (npc == pc) break;  // self jump ends the program
        pc = npc;
    end
endfunction

`endif

/* verification/rv_core_tb.sv */
`timescale 1ns/1ps

module rv_core_tb;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
    } store_t;

    logic                  clock;
    logic                  rst_n;
    rv_core_pkg::mem_req_t mem_req;
    rv_core_pkg::mem_rsp_t mem_rsp;

    logic [31:0] mem     [0:4095];
    logic [31:0] ref_mem [0:4095];
    store_t      exp_q [$];
    int          seed;
    int          n_prog;
    int          n_exec;
    logic        ref_done;

    `include "rv_core_ref.svh"

    rv_core_top dut (
        .clock     ( clock   ),
        .rst_n_i   ( rst_n   ),
        .mem_req_o ( mem_req ),
        .mem_rsp_i ( mem_rsp )
    );

    always #50 clock = ~clock;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped on error");
    endtask

    function automatic string format_store(input store_t s);
        return $sformatf("addr %h data %h strb %b", s.addr, s.data, s.strb);
    endfunction

    initial begin
        clock    = 1'b0;
        rst_n    = 1'b0;
        mem_rsp  = '0;
        ref_done = 1'b0;
        seed     = 32'hd282_d8b9;
        for (int i = 0; i < 4096; i++) mem[i] = (i * 32'h9e37_79b1) ^ 32'h1234_5678;
        gen_program();
        for (int i = 0; i < 4096; i++) ref_mem[i] = mem[i];
        rv_core_ref();
        ref_done = 1'b1;
        repeat (4) @(posedge clock);
        #1 rst_n = 1'b1;
    end

    // memory model serving one access at a time
    initial begin
        rv_core_pkg::mem_req_t req;
        logic [31:0] rdata;
        int lat;
        wait (ref_done);
        forever begin
            @(negedge clock);
            if (rst_n && mem_req.valid) begin
                req   = mem_req;
                rdata = mem[req.addr[13:2]];
                lat   = 1 + rnd(4);
                if (req.we) begin
                    for (int b = 0; b < 4; b++) begin
                        if (req.wstrb[b]) mem[req.addr[13:2]][8*b +: 8] = req.wdata[8*b +: 8];
                    end
                end
                repeat (lat) @(posedge clock);
                #1 mem_rsp = '{valid: 1'b1, rdata: rdata};
                @(posedge clock);
                #1 mem_rsp = '0;
            end
        end
    end

    // store stream compare
    initial begin
        store_t exp_st;
        store_t got;
        int     n;
        n = 0;
        wait (ref_done);
        while (exp_q.size() != 0) begin
            @(negedge clock);
            if (!rst_n) begin
                assert (!mem_req.valid)
                else stop_on_error("mem_req_o.valid is high while reset is asserted");
            end else if (mem_req.valid && mem_req.we) begin
                exp_st = exp_q.pop_front();
                got    = '{addr: mem_req.addr, data: mem_req.wdata, strb: mem_req.wstrb};
                assert (got == exp_st)
                else stop_on_error($sformatf("[FAIL] store_stream #%0d: expected %s, actual %s",
                                             n, format_store(exp_st), format_store(got)));
                n++;
            end
        end
        $display("%0d stores matched, %0d instructions executed", n, n_exec);
        $display("*** TEST PASSED ***");
        $finish;
    end

    initial begin
        longint limit_ns;
        wait (ref_done);
        limit_ns = longint'(n_exec) * 12 * 100 + 2000;
        #(limit_ns);
        stop_on_error($sformatf("timeout: %0d stores still expected after %0d ns",
                                exp_q.size(), limit_ns));
    end

endmodule

/* rv_core.f */
+incdir+verification
common/rv_core_pkg.sv
source/instr_decoder.sv
source/reg_file.sv
source/exec_unit.sv
fetch/fetch_unit.sv
lsu/load_store_unit.sv
source/mem_arbiter.sv
source/rv_core_top.sv
verification/rv_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the rv_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f rv_core.f --top-module rv_core_tb -o rv_core_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/rv_core_sim > sim.log 2>&1
status=$?
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
    echo "no result found in sim.log"
    exit 1
fi
exit 0
